// ==== source/front_end_config.svh ====
`ifndef FRONT_END_CONFIG_SVH
`define FRONT_END_CONFIG_SVH

// Width of every data word, instruction and address in the front end
`define XLEN 32

// Number of entries in the instruction buffer, must stay a power of two
`define IBUF_DEPTH 4

// Address of the first fetch after reset
`define RESET_PC 32'h0000_0000

// Encoding of ADDI x0 x0 0 that the decode register holds out of reset
`define NOP_INSTR 32'h0000_0013

`endif

// ==== source/front_end_pkg.sv ====
`default_nettype none

`include "front_end_config.svh"

package front_end_pkg;

    // One machine word, used for instructions, addresses and immediates
    typedef logic [`XLEN-1:0] data_word_t;

    // Index into the integer register file
    typedef logic [4:0] reg_addr_t;

    // Instruction class produced by the decoder
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU,
        OP_SYSTEM,
        OP_ILLEGAL
    } fe_opcode_e;

    // Exception raised by the front end for a decoded instruction
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_INSTR_MISALIGNED,
        EXC_ILLEGAL_INSTR
    } exc_cause_e;

    // Phases of the four-phase fetch handshake
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_RELEASE
    } fetch_state_e;

endpackage : front_end_pkg

`default_nettype wire

// ==== source/pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "front_end_config.svh"

module pc_gen
    import front_end_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  wire logic        exception_i,
    input  wire data_word_t  handler_pc_i,
    input  wire logic        handler_return_i,
    input  wire data_word_t  return_pc_i,
    input  wire logic        redirect_i,
    input  wire data_word_t  redirect_pc_i,

    input  wire logic        full_i,

    output logic             mem_req_o,
    output data_word_t       mem_addr_o,
    input  wire logic        mem_ack_i,
    input  wire data_word_t  mem_rdata_i,

    output logic             push_o,
    output data_word_t       push_word_o,
    output data_word_t       push_pc_o,

    output logic             flush_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    data_word_t   pc_q;
    data_word_t   pc_d;
    data_word_t   fetch_addr_q;
    data_word_t   word_q;
    logic         drop_q;
    logic         push_q;
    logic         any_redirect;
    logic         ack_seen;
    logic         accept;
    logic         start_req;

    assign any_redirect = exception_i | handler_return_i | redirect_i;
    assign ack_seen     = (state_q == FETCH_REQ) & mem_ack_i;

    // A word is kept only if no redirect came since its request was issued
    assign accept    = ack_seen & ~drop_q & ~any_redirect;
    assign start_req = (state_q == FETCH_IDLE) & ~full_i;

    // ======================================================================
    // Next PC selection
    // ======================================================================

    // Trap entry beats trap return, which beats a resolved branch or jump
    always_comb begin
        if (exception_i) begin
            pc_d = handler_pc_i;
        end else if (handler_return_i) begin
            pc_d = return_pc_i;
        end else if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (accept) begin
            pc_d = pc_q + `XLEN'(4);
        end else begin
            pc_d = pc_q;
        end
    end

    // ======================================================================
    // Four-phase fetch handshake
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (start_req) begin
                    state_d = FETCH_REQ;
                end
            end
            FETCH_REQ: begin
                if (mem_ack_i) begin
                    state_d = FETCH_RELEASE;
                end
            end
            FETCH_RELEASE: begin
                // Wait for the memory to drop its ack before the next request
                if (!mem_ack_i) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= FETCH_IDLE;
            pc_q         <= `RESET_PC;
            fetch_addr_q <= `RESET_PC;
            drop_q       <= 1'b0;
            push_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            push_q  <= accept;

            // The request address follows a redirect taken in the same cycle
            if (start_req) begin
                fetch_addr_q <= pc_d;
            end

            if (ack_seen) begin
                drop_q <= 1'b0;
            end else if (any_redirect && state_q == FETCH_REQ) begin
                drop_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ack_seen) begin
            word_q <= mem_rdata_i;
        end
    end

    assign mem_req_o   = (state_q == FETCH_REQ);
    assign mem_addr_o  = fetch_addr_q;
    assign push_o      = push_q;
    assign push_word_o = word_q;
    assign push_pc_o   = fetch_addr_q;
    assign flush_o     = any_redirect;

    // Memory sees a stable address until it acknowledges
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> $stable(mem_addr_o));

    // A new request never starts while the previous ack is still up
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_req |-> !mem_ack_i);

endmodule : pc_gen

`default_nettype wire

// ==== source/instr_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "front_end_config.svh"

module instr_buffer
    import front_end_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  wire logic        flush_i,
    input  wire logic        push_i,
    input  wire logic        pop_i,
    input  wire data_word_t  push_word_i,
    input  wire data_word_t  push_pc_i,

    output data_word_t       head_word_o,
    output data_word_t       head_pc_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = $clog2(`IBUF_DEPTH);

    data_word_t     word_mem [`IBUF_DEPTH];
    data_word_t     pc_mem   [`IBUF_DEPTH];
    logic [PTR_W:0] wr_ptr_q;
    logic [PTR_W:0] rd_ptr_q;
    logic           do_push;
    logic           do_pop;

    // A flush discards anything pushed or popped in the same cycle
    assign do_push = push_i & ~flush_i;
    assign do_pop  = pop_i & ~flush_i;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            word_mem[wr_ptr_q[PTR_W-1:0]] <= push_word_i;
            pc_mem[wr_ptr_q[PTR_W-1:0]]   <= push_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Equal indexes with different wrap bits mean every slot is taken
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                   && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    assign head_word_o = word_mem[rd_ptr_q[PTR_W-1:0]];
    assign head_pc_o   = pc_mem[rd_ptr_q[PTR_W-1:0]];

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i && full_o |-> pop_i);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule : instr_buffer

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "front_end_config.svh"

module decode_stage
    import front_end_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  wire logic        flush_i,
    input  wire logic        stall_i,

    input  wire logic        empty_i,
    input  wire data_word_t  head_word_i,
    input  wire data_word_t  head_pc_i,
    output logic             pop_o,

    output logic             dec_valid_o,
    output data_word_t       dec_pc_o,
    output data_word_t       dec_instr_o,
    output fe_opcode_e       dec_opcode_o,
    output reg_addr_t        dec_rd_o,
    output reg_addr_t        dec_rs1_o,
    output reg_addr_t        dec_rs2_o,
    output data_word_t       dec_imm_o,
    output exc_cause_e       dec_exc_o
);

    // Major opcode field, bits 6 to 2 of a 32-bit RV32I instruction
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    logic [6:0] opc_field;
    fe_opcode_e opcode;
    data_word_t imm;
    exc_cause_e cause;

    logic       valid_q;
    exc_cause_e exc_q;
    data_word_t instr_q;
    data_word_t pc_q;
    fe_opcode_e opcode_q;
    reg_addr_t  rd_q;
    reg_addr_t  rs1_q;
    reg_addr_t  rs2_q;
    data_word_t imm_q;

    // ======================================================================
    // Instruction decoder
    // ======================================================================

    assign opc_field = head_word_i[6:0];

    // Anything without the 32-bit length marker in bits 1 and 0 is illegal
    always_comb begin
        opcode = OP_ILLEGAL;
        if (opc_field[1:0] == 2'b11) begin
            case (opc_field[6:2])
                OPC_LUI:    opcode = OP_LUI;
                OPC_AUIPC:  opcode = OP_AUIPC;
                OPC_JAL:    opcode = OP_JAL;
                OPC_JALR:   opcode = OP_JALR;
                OPC_BRANCH: opcode = OP_BRANCH;
                OPC_LOAD:   opcode = OP_LOAD;
                OPC_STORE:  opcode = OP_STORE;
                OPC_OP_IMM: opcode = OP_ALU_IMM;
                OPC_OP:     opcode = OP_ALU;
                OPC_SYSTEM: opcode = OP_SYSTEM;
                default:    opcode = OP_ILLEGAL;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OP_JALR, OP_LOAD, OP_ALU_IMM: begin
                imm = {{20{head_word_i[31]}}, head_word_i[31:20]};
            end
            OP_STORE: begin
                imm = {{20{head_word_i[31]}}, head_word_i[31:25], head_word_i[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{head_word_i[31]}}, head_word_i[31], head_word_i[7],
                       head_word_i[30:25], head_word_i[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {head_word_i[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{head_word_i[31]}}, head_word_i[31], head_word_i[19:12],
                       head_word_i[20], head_word_i[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // A misaligned fetch address hides any decode error
    always_comb begin
        if (head_pc_i[1:0] != 2'b00) begin
            cause = EXC_INSTR_MISALIGNED;
        end else if (opcode == OP_ILLEGAL) begin
            cause = EXC_ILLEGAL_INSTR;
        end else begin
            cause = EXC_NONE;
        end
    end

    // ======================================================================
    // Decode register
    // ======================================================================

    assign pop_o = ~empty_i & ~stall_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            exc_q   <= EXC_NONE;
            instr_q <= `NOP_INSTR;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            exc_q   <= EXC_NONE;
        end else if (!stall_i) begin
            valid_q <= ~empty_i;
            if (pop_o) begin
                exc_q   <= cause;
                instr_q <= head_word_i;
            end else begin
                exc_q <= EXC_NONE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            pc_q     <= head_pc_i;
            opcode_q <= opcode;
            rd_q     <= head_word_i[11:7];
            rs1_q    <= head_word_i[19:15];
            rs2_q    <= head_word_i[24:20];
            imm_q    <= imm;
        end
    end

    assign dec_valid_o  = valid_q;
    assign dec_pc_o     = pc_q;
    assign dec_instr_o  = instr_q;
    assign dec_opcode_o = opcode_q;
    assign dec_rd_o     = rd_q;
    assign dec_rs1_o    = rs1_q;
    assign dec_rs2_o    = rs2_q;
    assign dec_imm_o    = imm_q;
    assign dec_exc_o    = exc_q;

    // The back end never sees a cause without a valid instruction
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_exc_o != EXC_NONE |-> dec_valid_o);

endmodule : decode_stage

`default_nettype wire

// ==== source/front_end.sv ====
`timescale 1ns/1ns
`default_nettype none

module front_end
    import front_end_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  wire logic        exception_i,
    input  wire logic        handler_return_i,
    input  wire logic        redirect_i,
    input  wire data_word_t  handler_pc_i,
    input  wire data_word_t  return_pc_i,
    input  wire data_word_t  redirect_pc_i,

    input  wire logic        stall_i,

    output logic             mem_req_o,
    output data_word_t       mem_addr_o,
    input  wire logic        mem_ack_i,
    input  wire data_word_t  mem_rdata_i,

    output logic             dec_valid_o,
    output data_word_t       dec_pc_o,
    output data_word_t       dec_instr_o,
    output fe_opcode_e       dec_opcode_o,
    output reg_addr_t        dec_rd_o,
    output reg_addr_t        dec_rs1_o,
    output reg_addr_t        dec_rs2_o,
    output data_word_t       dec_imm_o,
    output exc_cause_e       dec_exc_o
);

    logic       push;
    data_word_t push_word;
    data_word_t push_pc;
    logic       full;
    logic       flush;
    logic       empty;
    data_word_t head_word;
    data_word_t head_pc;
    logic       pop;

    // ======================================================================
    // Fetch, buffer and decode
    // ======================================================================

    pc_gen u_pc_gen (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .exception_i      ( exception_i      ),
        .handler_pc_i     ( handler_pc_i     ),
        .handler_return_i ( handler_return_i ),
        .return_pc_i      ( return_pc_i      ),
        .redirect_i       ( redirect_i       ),
        .redirect_pc_i    ( redirect_pc_i    ),
        .full_i           ( full             ),
        .mem_req_o        ( mem_req_o        ),
        .mem_addr_o       ( mem_addr_o       ),
        .mem_ack_i        ( mem_ack_i        ),
        .mem_rdata_i      ( mem_rdata_i      ),
        .push_o           ( push             ),
        .push_word_o      ( push_word        ),
        .push_pc_o        ( push_pc          ),
        .flush_o          ( flush            )
    );

    instr_buffer u_instr_buffer (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .flush_i     ( flush     ),
        .push_i      ( push      ),
        .pop_i       ( pop       ),
        .push_word_i ( push_word ),
        .push_pc_i   ( push_pc   ),
        .head_word_o ( head_word ),
        .head_pc_o   ( head_pc   ),
        .empty_o     ( empty     ),
        .full_o      ( full      )
    );

    decode_stage u_decode_stage (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .flush_i      ( flush        ),
        .stall_i      ( stall_i      ),
        .empty_i      ( empty        ),
        .head_word_i  ( head_word    ),
        .head_pc_i    ( head_pc      ),
        .pop_o        ( pop          ),
        .dec_valid_o  ( dec_valid_o  ),
        .dec_pc_o     ( dec_pc_o     ),
        .dec_instr_o  ( dec_instr_o  ),
        .dec_opcode_o ( dec_opcode_o ),
        .dec_rd_o     ( dec_rd_o     ),
        .dec_rs1_o    ( dec_rs1_o    ),
        .dec_rs2_o    ( dec_rs2_o    ),
        .dec_imm_o    ( dec_imm_o    ),
        .dec_exc_o    ( dec_exc_o    )
    );

endmodule : front_end

`default_nettype wire

// ==== dv/fetch_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_mem_model
    import front_end_pkg::*;
#(
    parameter int          DEPTH = 256,
    parameter logic [31:0] SEED  = 32'h6666_3724
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       mem_req_i,
    input  wire data_word_t mem_addr_i,
    output logic            mem_ack_o,
    output data_word_t      mem_rdata_o
);

    localparam int IDX_W = $clog2(DEPTH);

    data_word_t words [DEPTH];
    integer     seed;
    int         delay;
    logic       pending;

    initial begin
        seed        = SEED;
        mem_ack_o   = 1'b0;
        mem_rdata_o = '0;
        delay       = 0;
        pending     = 1'b0;
    end

    task automatic write_word(input int index, input data_word_t word);
        words[index] = word;
    endtask

    // Responses change on the falling edge, half a cycle away from the DUT's sampling edge
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            mem_ack_o <= 1'b0;
            pending = 1'b0;
        end else if (mem_ack_o) begin
            // Ack stays up until the request is withdrawn
            if (!mem_req_i) begin
                mem_ack_o <= 1'b0;
            end
        end else if (mem_req_i) begin
            if (!pending) begin
                delay   = $unsigned($random(seed)) % 4;
                pending = 1'b1;
            end
            if (delay == 0) begin
                mem_rdata_o <= words[mem_addr_i[IDX_W+1:2]];
                mem_ack_o   <= 1'b1;
                pending = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end
    end

endmodule : fetch_mem_model

`default_nettype wire

// ==== dv/front_end_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "front_end_config.svh"

module front_end_tb
    import front_end_pkg::*;
();

    localparam int          MEM_WORDS       = 256;
    localparam logic [31:0] RANDOM_SEED     = 32'h6666_3724;
    localparam int          TEST_COUNT      = 5;
    localparam int          CYCLES_PER_TEST = 600;
    localparam int          TIMEOUT_CYCLES  = TEST_COUNT * CYCLES_PER_TEST + 1000;

    logic       clk;
    logic       rst_n;
    logic       exception;
    logic       handler_return;
    logic       redirect;
    data_word_t handler_pc;
    data_word_t return_pc;
    data_word_t redirect_pc;
    logic       stall;
    logic       mem_req;
    data_word_t mem_addr;
    logic       mem_ack;
    data_word_t mem_rdata;
    logic       dec_valid;
    data_word_t dec_pc;
    data_word_t dec_instr;
    fe_opcode_e dec_opcode;
    reg_addr_t  dec_rd;
    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    data_word_t dec_imm;
    exc_cause_e dec_exc;

    // Scoreboard state
    data_word_t image [MEM_WORDS];
    data_word_t exp_pc;
    integer     seed;
    int         errors          = 0;
    int         decoded         = 0;
    int         cycles          = 0;
    int         illegal_seen    = 0;
    int         misaligned_seen = 0;

    // Decode outputs seen at the previous falling edge
    logic       last_valid = 1'b0;
    data_word_t last_pc;
    data_word_t last_instr;
    data_word_t last_imm;
    fe_opcode_e last_opcode;
    reg_addr_t  last_rd;
    reg_addr_t  last_rs1;
    reg_addr_t  last_rs2;
    exc_cause_e last_exc;

    front_end dut (
        .clk_i            ( clk            ),
        .rst_n_i          ( rst_n          ),
        .exception_i      ( exception      ),
        .handler_return_i ( handler_return ),
        .redirect_i       ( redirect       ),
        .handler_pc_i     ( handler_pc     ),
        .return_pc_i      ( return_pc      ),
        .redirect_pc_i    ( redirect_pc    ),
        .stall_i          ( stall          ),
        .mem_req_o        ( mem_req        ),
        .mem_addr_o       ( mem_addr       ),
        .mem_ack_i        ( mem_ack        ),
        .mem_rdata_i      ( mem_rdata      ),
        .dec_valid_o      ( dec_valid      ),
        .dec_pc_o         ( dec_pc         ),
        .dec_instr_o      ( dec_instr      ),
        .dec_opcode_o     ( dec_opcode     ),
        .dec_rd_o         ( dec_rd         ),
        .dec_rs1_o        ( dec_rs1        ),
        .dec_rs2_o        ( dec_rs2        ),
        .dec_imm_o        ( dec_imm        ),
        .dec_exc_o        ( dec_exc        )
    );

    fetch_mem_model #(
        .DEPTH ( MEM_WORDS   ),
        .SEED  ( RANDOM_SEED )
    ) u_mem (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .mem_req_i   ( mem_req   ),
        .mem_addr_i  ( mem_addr  ),
        .mem_ack_o   ( mem_ack   ),
        .mem_rdata_o ( mem_rdata )
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Error: timeout after %0d cycles, decoded output stopped arriving", cycles);
            $display("Summary: %0d errors, %0d instructions checked", errors, decoded);
            $display("tests failed");
            $finish;
        end
    end

    // ======================================================================
    // Reference decoder
    // ======================================================================

    function automatic logic [6:0] legal_opcode(input int k);
        case (k)
            0:       return 7'h37;
            1:       return 7'h17;
            2:       return 7'h6f;
            3:       return 7'h67;
            4:       return 7'h63;
            5:       return 7'h03;
            6:       return 7'h23;
            7:       return 7'h13;
            8:       return 7'h33;
            default: return 7'h73;
        endcase
    endfunction

    task automatic reference_decode(input data_word_t word, input data_word_t pc,
                                    output fe_opcode_e opc, output data_word_t imm,
                                    output exc_cause_e cause);
        data_word_t  itype;
        logic [12:0] boff;
        logic [20:0] joff;
        case (word[6:0])
            7'h37:   opc = OP_LUI;
            7'h17:   opc = OP_AUIPC;
            7'h6f:   opc = OP_JAL;
            7'h67:   opc = OP_JALR;
            7'h63:   opc = OP_BRANCH;
            7'h03:   opc = OP_LOAD;
            7'h23:   opc = OP_STORE;
            7'h13:   opc = OP_ALU_IMM;
            7'h33:   opc = OP_ALU;
            7'h73:   opc = OP_SYSTEM;
            default: opc = OP_ILLEGAL;
        endcase
        itype = $signed(word) >>> 20;
        boff  = {word[31], word[7], word[30:25], word[11:8], 1'b0};
        joff  = {word[31], word[19:12], word[20], word[30:21], 1'b0};
        case (opc)
            OP_LUI, OP_AUIPC:             imm = word & 32'hffff_f000;
            OP_JALR, OP_LOAD, OP_ALU_IMM: imm = itype;
            OP_STORE:                     imm = {itype[31:5], word[11:7]};
            OP_BRANCH:                    imm = {{19{boff[12]}}, boff};
            OP_JAL:                       imm = {{11{joff[20]}}, joff};
            default:                      imm = '0;
        endcase
        if (pc[1:0] != 2'b00) begin
            cause = EXC_INSTR_MISALIGNED;
        end else if (opc == OP_ILLEGAL) begin
            cause = EXC_ILLEGAL_INSTR;
        end else begin
            cause = EXC_NONE;
        end
    endtask

    // ======================================================================
    // Checking and cycle stepping
    // ======================================================================

    task automatic compare_value(input string what, input data_word_t got,
                                 input data_word_t want);
        assert (got === want) else begin
            errors++;
            $display("Mismatch at %0t: %s at pc %h is %h, expected %h",
                     $time, what, exp_pc, got, want);
        end
    endtask

    task automatic check_decoded();
        data_word_t word;
        fe_opcode_e opc;
        data_word_t imm;
        exc_cause_e cause;
        word = image[exp_pc[9:2]];
        reference_decode(word, exp_pc, opc, imm, cause);
        compare_value("pc", dec_pc, exp_pc);
        compare_value("instr", dec_instr, word);
        compare_value("opcode", 32'(dec_opcode), 32'(opc));
        compare_value("rd", 32'(dec_rd), 32'(word[11:7]));
        compare_value("rs1", 32'(dec_rs1), 32'(word[19:15]));
        compare_value("rs2", 32'(dec_rs2), 32'(word[24:20]));
        compare_value("imm", dec_imm, imm);
        compare_value("cause", 32'(dec_exc), 32'(cause));
        if (dec_exc == EXC_ILLEGAL_INSTR) begin
            illegal_seen++;
        end
        if (dec_exc == EXC_INSTR_MISALIGNED) begin
            misaligned_seen++;
        end
        exp_pc = exp_pc + 32'd4;
        decoded++;
    endtask

    // Stall and redirect still hold the values that were in effect at the last rising edge
    task automatic sample_outputs();
        logic stalled;
        logic flushed;
        stalled = stall;
        flushed = exception | handler_return | redirect;
        if (stalled && !flushed) begin
            assert (dec_valid === last_valid && (!last_valid ||
                    (dec_pc === last_pc && dec_instr === last_instr &&
                     dec_imm === last_imm && dec_opcode === last_opcode &&
                     dec_rd === last_rd && dec_rs1 === last_rs1 &&
                     dec_rs2 === last_rs2 && dec_exc === last_exc))) else begin
                errors++;
                $display("Mismatch at %0t: decode outputs changed while stalled at pc %h",
                         $time, last_pc);
            end
        end else if (dec_valid) begin
            check_decoded();
        end
        last_valid  = dec_valid;
        last_pc     = dec_pc;
        last_instr  = dec_instr;
        last_imm    = dec_imm;
        last_opcode = dec_opcode;
        last_rd     = dec_rd;
        last_rs1    = dec_rs1;
        last_rs2    = dec_rs2;
        last_exc    = dec_exc;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (rst_n) begin
            sample_outputs();
        end
    endtask

    task automatic wait_for_outputs(input int count);
        int goal;
        goal = decoded + count;
        while (decoded < goal) begin
            next_cycle();
        end
    endtask

    task automatic load_word(input int index, input data_word_t word);
        image[index] = word;
        u_mem.write_word(index, word);
    endtask

    task automatic fill_memory();
        data_word_t word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word      = $random(seed);
            word[6:0] = legal_opcode($unsigned($random(seed)) % 10);
            load_word(i, word);
        end
    endtask

    // Expected target follows trap entry, then trap return, then branch
    task automatic apply_redirects(input logic take_exc, input logic take_ret,
                                   input logic take_br);
        exception      = take_exc;
        handler_return = take_ret;
        redirect       = take_br;
        if (take_exc) begin
            exp_pc = handler_pc;
        end else if (take_ret) begin
            exp_pc = return_pc;
        end else if (take_br) begin
            exp_pc = redirect_pc;
        end
        next_cycle();
        exception      = 1'b0;
        handler_return = 1'b0;
        redirect       = 1'b0;
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic fetch_after_reset();
        repeat (4) next_cycle();
        assert (mem_req === 1'b0 && dec_valid === 1'b0 && dec_exc === EXC_NONE &&
                dec_instr === `NOP_INSTR) else begin
            errors++;
            $display("Mismatch at %0t: request, valid, cause or instruction not idle in reset",
                     $time);
        end
        rst_n = 1'b1;
        wait_for_outputs(12);
    endtask

    task automatic stall_randomly();
        int goal;
        int stretch;
        goal    = decoded + 30;
        stretch = 0;
        while (decoded < goal) begin
            if (stretch == 0) begin
                stall   = ~stall;
                stretch = 1 + ($unsigned($random(seed)) % 8);
            end
            stretch--;
            next_cycle();
        end
        stall = 1'b0;
    endtask

    task automatic follow_branch();
        redirect_pc = 32'h0000_0200;
        apply_redirects(1'b0, 1'b0, 1'b1);
        wait_for_outputs(8);
    endtask

    task automatic enter_and_leave_trap();
        handler_pc  = 32'h0000_0300;
        redirect_pc = 32'h0000_0100;
        apply_redirects(1'b1, 1'b0, 1'b1);
        wait_for_outputs(4);
        return_pc = 32'h0000_0104;
        apply_redirects(1'b0, 1'b1, 1'b0);
        wait_for_outputs(4);
    endtask

    task automatic decode_faults();
        int illegal_before;
        int misaligned_before;
        // A custom-0 opcode and a word without the 32-bit length marker
        load_word(32'h380 >> 2, 32'h0000_000b);
        load_word(32'h384 >> 2, 32'h1234_5600);
        illegal_before = illegal_seen;
        redirect_pc    = 32'h0000_0380;
        apply_redirects(1'b0, 1'b0, 1'b1);
        wait_for_outputs(3);
        assert (illegal_seen >= illegal_before + 2) else begin
            errors++;
            $display("Error: unknown opcodes were not reported as illegal instructions");
        end
        misaligned_before = misaligned_seen;
        redirect_pc       = 32'h0000_03c2;
        apply_redirects(1'b0, 1'b0, 1'b1);
        wait_for_outputs(3);
        assert (misaligned_seen >= misaligned_before + 3) else begin
            errors++;
            $display("Error: fetches at a misaligned pc were not reported as misaligned");
        end
    endtask

    initial begin
        seed           = RANDOM_SEED;
        rst_n          = 1'b0;
        exception      = 1'b0;
        handler_return = 1'b0;
        redirect       = 1'b0;
        handler_pc     = '0;
        return_pc      = '0;
        redirect_pc    = '0;
        stall          = 1'b0;
        exp_pc         = `RESET_PC;
        fill_memory();

        fetch_after_reset();
        stall_randomly();
        follow_branch();
        enter_and_leave_trap();
        decode_faults();

        $display("Summary: %0d errors, %0d instructions checked", errors, decoded);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : front_end_tb

`default_nettype wire

// ==== all.f ====
+incdir+source
source/front_end_pkg.sv
source/pc_gen.sv
source/instr_buffer.sv
source/decode_stage.sv
source/front_end.sv
dv/fetch_mem_model.sv
dv/front_end_tb.sv
